// File: hdl/csr_config.svh
// Fixed architecture widths and CSR constants, included by the RTL and the testbench
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Data path width of an RV64 core
`define CSR_XLEN 64

// CSR address width taken from the instruction encoding
`define CSR_ADDR_W 12

// misa contents for RV64I
// MXL=2 in bits 63:62 selects 64-bit, bit 8 is the I base ISA
`define CSR_MISA_VALUE 64'h8000_0000_0000_0100

// Bit position of the low mepc bit that is always cleared
`define CSR_MEPC_ALIGN_BIT 0

`endif

// File: hdl/csr_pkg.sv
// Shared CSR types and register addresses, imported by the RTL and the testbench model
`include "csr_config.svh"

package csr_pkg;

    // Access opcodes carried on req_op
    typedef enum logic [1:0] {
        CSR_OP_READ  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    // Interconnect grant state
    typedef enum logic {
        IC_IDLE = 1'b0,
        IC_BUSY = 1'b1
    } ic_state_e;

    // Machine-mode registers implemented by the CSR file
    // misa is read-only; the others are read/write with legalization on some fields
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDR_MISA     = 12'h301;
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDR_MTVEC    = 12'h305;
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDR_MSCRATCH = 12'h340;
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDR_MEPC     = 12'h341;
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDR_MCAUSE   = 12'h342;

endpackage

// File: hdl/csr_ic_m2_s1.sv
// Two-master, one-slave CSR interconnect; grants one master until its response is taken
`include "csr_config.svh"

module csr_ic_m2_s1 import csr_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    // Master 0, pipeline CSR port
    input  logic                   i_m0_req_valid,
    output logic                   o_m0_req_ready,
    input  csr_op_e                i_m0_req_op,
    input  logic [`CSR_ADDR_W-1:0] i_m0_req_addr,
    input  logic [`CSR_XLEN-1:0]   i_m0_req_data,
    output logic                   o_m0_resp_valid,
    input  logic                   i_m0_resp_ready,
    output logic [`CSR_XLEN-1:0]   o_m0_resp_data,
    output logic                   o_m0_resp_exception,
    // Master 1, debug port
    input  logic                   i_m1_req_valid,
    output logic                   o_m1_req_ready,
    input  csr_op_e                i_m1_req_op,
    input  logic [`CSR_ADDR_W-1:0] i_m1_req_addr,
    input  logic [`CSR_XLEN-1:0]   i_m1_req_data,
    output logic                   o_m1_resp_valid,
    input  logic                   i_m1_resp_ready,
    output logic [`CSR_XLEN-1:0]   o_m1_resp_data,
    output logic                   o_m1_resp_exception,
    // Slave 0, CSR file
    output logic                   o_s0_req_valid,
    input  logic                   i_s0_req_ready,
    output csr_op_e                o_s0_req_op,
    output logic [`CSR_ADDR_W-1:0] o_s0_req_addr,
    output logic [`CSR_XLEN-1:0]   o_s0_req_data,
    input  logic                   i_s0_resp_valid,
    output logic                   o_s0_resp_ready,
    input  logic [`CSR_XLEN-1:0]   i_s0_resp_data,
    input  logic                   i_s0_resp_exception
);

    ic_state_e state_q;
    ic_state_e state_d;
    logic      midx_q;
    logic      midx_d;
    logic      sel;
    logic      grant_resp_done;

    // While idle, route the master that wins; master 0 has priority
    always_comb begin
        if (state_q == IC_IDLE) begin
            sel = ~i_m0_req_valid & i_m1_req_valid;
        end else begin
            sel = midx_q;
        end
    end

    assign grant_resp_done = i_s0_resp_valid & (midx_q ? i_m1_resp_ready : i_m0_resp_ready);

    always_comb begin
        state_d = state_q;
        midx_d  = midx_q;
        case (state_q)
            IC_IDLE: begin
                if (i_m0_req_valid | i_m1_req_valid) begin
                    state_d = IC_BUSY;
                    midx_d  = sel;
                end
            end
            IC_BUSY: begin
                // Release only after the granted master takes its response
                if (grant_resp_done) begin
                    state_d = IC_IDLE;
                end
            end
            default: state_d = IC_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= IC_IDLE;
            midx_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            midx_q  <= midx_d;
        end
    end

    // Request path towards the slave
    assign o_s0_req_valid  = sel ? i_m1_req_valid  : i_m0_req_valid;
    assign o_s0_req_op     = sel ? i_m1_req_op     : i_m0_req_op;
    assign o_s0_req_addr   = sel ? i_m1_req_addr   : i_m0_req_addr;
    assign o_s0_req_data   = sel ? i_m1_req_data   : i_m0_req_data;
    assign o_s0_resp_ready = sel ? i_m1_resp_ready : i_m0_resp_ready;

    // Return path, the master without the bus sees zeros
    assign o_m0_req_ready      = ~sel & i_s0_req_ready;
    assign o_m0_resp_valid     = ~sel & i_s0_resp_valid;
    assign o_m0_resp_data      = sel ? '0 : i_s0_resp_data;
    assign o_m0_resp_exception = ~sel & i_s0_resp_exception;
    assign o_m1_req_ready      = sel & i_s0_req_ready;
    assign o_m1_resp_valid     = sel & i_s0_resp_valid;
    assign o_m1_resp_data      = sel ? i_s0_resp_data : '0;
    assign o_m1_resp_exception = sel & i_s0_resp_exception;

    // The CSR file must only answer a master that holds the grant
    a_m0_resp_granted: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_m0_resp_valid |-> (state_q == IC_BUSY) && !midx_q);
    a_m1_resp_granted: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_m1_resp_valid |-> (state_q == IC_BUSY) && midx_q);

endmodule

// File: hdl/csr_regfile.sv
// Machine-mode CSR file; executes one access at a time and returns the old value
`include "csr_config.svh"

module csr_regfile import csr_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    // Request channel
    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    input  csr_op_e                i_req_op,
    input  logic [`CSR_ADDR_W-1:0] i_req_addr,
    input  logic [`CSR_XLEN-1:0]   i_req_data,
    // Response channel
    output logic                   o_resp_valid,
    input  logic                   i_resp_ready,
    output logic [`CSR_XLEN-1:0]   o_resp_data,
    output logic                   o_resp_exception
);

    // Architectural registers
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;

    // Response slot
    logic                 init_done_q;
    logic                 resp_valid_q;
    logic [`CSR_XLEN-1:0] resp_data_q;
    logic                 resp_exc_q;

    logic                 req_fire;
    logic                 resp_fire;
    logic                 addr_mapped;
    logic                 read_only;
    logic                 modify;
    logic                 exc;
    logic                 wr_en;
    logic [`CSR_XLEN-1:0] old_value;
    logic [`CSR_XLEN-1:0] new_value;
    logic [`CSR_XLEN-1:0] mtvec_legal;
    logic [`CSR_XLEN-1:0] mepc_legal;

    // Ready once out of reset and no response is pending
    assign o_req_ready = init_done_q & ~resp_valid_q;
    assign req_fire    = i_req_valid & o_req_ready;
    assign resp_fire   = resp_valid_q & i_resp_ready;

    // Address decode and old value read
    always_comb begin
        addr_mapped = 1'b1;
        read_only   = 1'b0;
        case (i_req_addr)
            CSR_ADDR_MISA: begin
                old_value = `CSR_MISA_VALUE;
                read_only = 1'b1;
            end
            CSR_ADDR_MTVEC:    old_value = mtvec_q;
            CSR_ADDR_MSCRATCH: old_value = mscratch_q;
            CSR_ADDR_MEPC:     old_value = mepc_q;
            CSR_ADDR_MCAUSE:   old_value = mcause_q;
            default: begin
                addr_mapped = 1'b0;
                old_value   = '0;
            end
        endcase
    end

    // Opcode execution
    always_comb begin
        case (i_req_op)
            CSR_OP_WRITE: new_value = i_req_data;
            CSR_OP_SET:   new_value = old_value | i_req_data;
            CSR_OP_CLEAR: new_value = old_value & ~i_req_data;
            default:      new_value = old_value;
        endcase
    end

    assign modify = (i_req_op != CSR_OP_READ);
    assign exc    = ~addr_mapped | (read_only & modify);
    assign wr_en  = req_fire & modify & ~exc;

    // mtvec MODE keeps direct (0) and vectored (1); reserved values become direct
    assign mtvec_legal = {new_value[`CSR_XLEN-1:2], new_value[1] ? 2'b00 : new_value[1:0]};

    // mepc is at least 2-byte aligned
    always_comb begin
        mepc_legal = new_value;
        mepc_legal[`CSR_MEPC_ALIGN_BIT] = 1'b0;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (wr_en) begin
            case (i_req_addr)
                CSR_ADDR_MTVEC:    mtvec_q    <= mtvec_legal;
                CSR_ADDR_MSCRATCH: mscratch_q <= new_value;
                CSR_ADDR_MEPC:     mepc_q     <= mepc_legal;
                CSR_ADDR_MCAUSE:   mcause_q   <= new_value;
                default: ;
            endcase
        end
    end

    // One access in flight; the response comes the cycle after acceptance
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            init_done_q  <= 1'b0;
            resp_valid_q <= 1'b0;
        end else begin
            init_done_q <= 1'b1;
            if (req_fire) begin
                resp_valid_q <= 1'b1;
            end else if (resp_fire) begin
                resp_valid_q <= 1'b0;
            end
        end
    end

    // Faulting accesses return zero data
    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            resp_data_q <= exc ? '0 : old_value;
            resp_exc_q  <= exc;
        end
    end

    assign o_resp_valid     = resp_valid_q;
    assign o_resp_data      = resp_data_q;
    assign o_resp_exception = resp_exc_q;

    // A stalled response holds its payload until the master takes it
    a_resp_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid && !i_resp_ready |=>
            o_resp_valid && $stable(o_resp_data) && $stable(o_resp_exception));

endmodule

// File: hdl/csr_subsystem.sv
// CSR access path top level; pipeline and debug ports share the CSR file via the interconnect
`include "csr_config.svh"

module csr_subsystem import csr_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    // Master 0, pipeline CSR port
    input  logic                   i_m0_req_valid,
    output logic                   o_m0_req_ready,
    input  csr_op_e                i_m0_req_op,
    input  logic [`CSR_ADDR_W-1:0] i_m0_req_addr,
    input  logic [`CSR_XLEN-1:0]   i_m0_req_data,
    output logic                   o_m0_resp_valid,
    input  logic                   i_m0_resp_ready,
    output logic [`CSR_XLEN-1:0]   o_m0_resp_data,
    output logic                   o_m0_resp_exception,
    // Master 1, debug port
    input  logic                   i_m1_req_valid,
    output logic                   o_m1_req_ready,
    input  csr_op_e                i_m1_req_op,
    input  logic [`CSR_ADDR_W-1:0] i_m1_req_addr,
    input  logic [`CSR_XLEN-1:0]   i_m1_req_data,
    output logic                   o_m1_resp_valid,
    input  logic                   i_m1_resp_ready,
    output logic [`CSR_XLEN-1:0]   o_m1_resp_data,
    output logic                   o_m1_resp_exception
);

    // Slave link between interconnect and CSR file
    logic                   s0_req_valid;
    logic                   s0_req_ready;
    csr_op_e                s0_req_op;
    logic [`CSR_ADDR_W-1:0] s0_req_addr;
    logic [`CSR_XLEN-1:0]   s0_req_data;
    logic                   s0_resp_valid;
    logic                   s0_resp_ready;
    logic [`CSR_XLEN-1:0]   s0_resp_data;
    logic                   s0_resp_exception;

    csr_ic_m2_s1 u_csr_ic_m2_s1 (
        .i_clk               (i_clk),
        .i_nrst              (i_nrst),
        .i_m0_req_valid      (i_m0_req_valid),
        .o_m0_req_ready      (o_m0_req_ready),
        .i_m0_req_op         (i_m0_req_op),
        .i_m0_req_addr       (i_m0_req_addr),
        .i_m0_req_data       (i_m0_req_data),
        .o_m0_resp_valid     (o_m0_resp_valid),
        .i_m0_resp_ready     (i_m0_resp_ready),
        .o_m0_resp_data      (o_m0_resp_data),
        .o_m0_resp_exception (o_m0_resp_exception),
        .i_m1_req_valid      (i_m1_req_valid),
        .o_m1_req_ready      (o_m1_req_ready),
        .i_m1_req_op         (i_m1_req_op),
        .i_m1_req_addr       (i_m1_req_addr),
        .i_m1_req_data       (i_m1_req_data),
        .o_m1_resp_valid     (o_m1_resp_valid),
        .i_m1_resp_ready     (i_m1_resp_ready),
        .o_m1_resp_data      (o_m1_resp_data),
        .o_m1_resp_exception (o_m1_resp_exception),
        .o_s0_req_valid      (s0_req_valid),
        .i_s0_req_ready      (s0_req_ready),
        .o_s0_req_op         (s0_req_op),
        .o_s0_req_addr       (s0_req_addr),
        .o_s0_req_data       (s0_req_data),
        .i_s0_resp_valid     (s0_resp_valid),
        .o_s0_resp_ready     (s0_resp_ready),
        .i_s0_resp_data      (s0_resp_data),
        .i_s0_resp_exception (s0_resp_exception)
    );

    csr_regfile u_csr_regfile (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_req_valid      (s0_req_valid),
        .o_req_ready      (s0_req_ready),
        .i_req_op         (s0_req_op),
        .i_req_addr       (s0_req_addr),
        .i_req_data       (s0_req_data),
        .o_resp_valid     (s0_resp_valid),
        .i_resp_ready     (s0_resp_ready),
        .o_resp_data      (s0_resp_data),
        .o_resp_exception (s0_resp_exception)
    );

endmodule

// File: test/tb_csr_subsystem.sv
// Self-checking testbench for the CSR subsystem, compiled from filelist.f as the simulation top
`include "csr_config.svh"

module tb_csr_subsystem import csr_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int STREAM_LEN     = 40;
    localparam logic [`CSR_ADDR_W-1:0] CSR_ADDRS [5] = '{
        CSR_ADDR_MISA, CSR_ADDR_MTVEC, CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE
    };

    logic                   clk;
    logic                   nrst;
    logic                   req_valid [2];
    logic                   req_ready [2];
    csr_op_e                req_op [2];
    logic [`CSR_ADDR_W-1:0] req_addr [2];
    logic [`CSR_XLEN-1:0]   req_data [2];
    logic                   resp_valid [2];
    logic                   resp_ready [2] = '{1'b1, 1'b1};
    logic [`CSR_XLEN-1:0]   resp_data [2];
    logic                   resp_exc [2];

    // Reference model and expected responses, {exception, data} per entry
    logic [`CSR_XLEN-1:0]   model_reg [5];
    logic [`CSR_XLEN:0]     exp_q0 [$];
    logic [`CSR_XLEN:0]     exp_q1 [$];
    int                     pend [2] = '{0, 0};
    logic [`CSR_XLEN-1:0]   exp_data [2] = '{'0, '0};
    logic                   exp_exc [2] = '{1'b0, 1'b0};

    // Handshakes seen on the falling edge, applied on the next rising edge
    logic                   req_seen [2] = '{1'b0, 1'b0};
    logic                   resp_seen [2] = '{1'b0, 1'b0};
    csr_op_e                seen_op [2];
    logic [`CSR_ADDR_W-1:0] seen_addr [2];
    logic [`CSR_XLEN-1:0]   seen_data [2];

    logic [31:0]            lfsr_state;
    logic                   stall_en;
    csr_op_e                rnd_op [2][STREAM_LEN];
    logic [`CSR_ADDR_W-1:0] rnd_addr [2][STREAM_LEN];
    logic [`CSR_XLEN-1:0]   rnd_data [2][STREAM_LEN];

    csr_subsystem u_csr_subsystem (
        .i_clk               (clk),
        .i_nrst              (nrst),
        .i_m0_req_valid      (req_valid[0]),
        .o_m0_req_ready      (req_ready[0]),
        .i_m0_req_op         (req_op[0]),
        .i_m0_req_addr       (req_addr[0]),
        .i_m0_req_data       (req_data[0]),
        .o_m0_resp_valid     (resp_valid[0]),
        .i_m0_resp_ready     (resp_ready[0]),
        .o_m0_resp_data      (resp_data[0]),
        .o_m0_resp_exception (resp_exc[0]),
        .i_m1_req_valid      (req_valid[1]),
        .o_m1_req_ready      (req_ready[1]),
        .i_m1_req_op         (req_op[1]),
        .i_m1_req_addr       (req_addr[1]),
        .i_m1_req_data       (req_data[1]),
        .o_m1_resp_valid     (resp_valid[1]),
        .i_m1_resp_ready     (resp_ready[1]),
        .o_m1_resp_data      (resp_data[1]),
        .o_m1_resp_exception (resp_exc[1])
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic stop_on_timeout(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [`CSR_XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[`CSR_XLEN-2:0], lfsr_state[0]};
        end
    endtask

    function automatic int reg_index(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_ADDR_MISA:     return 0;
            CSR_ADDR_MTVEC:    return 1;
            CSR_ADDR_MSCRATCH: return 2;
            CSR_ADDR_MEPC:     return 3;
            CSR_ADDR_MCAUSE:   return 4;
            default:           return -1;
        endcase
    endfunction

    // One access on the model; the old value comes back unless the access faults
    task automatic model_access(input int m, input csr_op_e op,
                                input logic [`CSR_ADDR_W-1:0] addr,
                                input logic [`CSR_XLEN-1:0] wdata);
        int                   idx;
        logic [`CSR_XLEN-1:0] old_val;
        logic [`CSR_XLEN-1:0] new_val;
        logic [`CSR_XLEN:0]   entry;
        idx = reg_index(addr);
        if (idx < 0 || (idx == 0 && op != CSR_OP_READ)) begin
            entry = {1'b1, {`CSR_XLEN{1'b0}}};
        end else begin
            old_val = model_reg[idx];
            case (op)
                CSR_OP_WRITE: new_val = wdata;
                CSR_OP_SET:   new_val = old_val | wdata;
                CSR_OP_CLEAR: new_val = old_val & ~wdata;
                default:      new_val = old_val;
            endcase
            // Reserved mtvec modes fall back to direct
            if (idx == 1 && new_val[1:0] > 2'd1) begin
                new_val[1:0] = 2'd0;
            end
            if (idx == 3) begin
                new_val[0] = 1'b0;
            end
            if (idx != 0) begin
                model_reg[idx] = new_val;
            end
            entry = {1'b0, old_val};
        end
        if (m == 0) begin
            exp_q0.push_back(entry);
        end else begin
            exp_q1.push_back(entry);
        end
    endtask

    task automatic refresh_front();
        pend[0]     = exp_q0.size();
        pend[1]     = exp_q1.size();
        exp_data[0] = (pend[0] > 0) ? exp_q0[0][`CSR_XLEN-1:0] : '0;
        exp_exc[0]  = (pend[0] > 0) ? exp_q0[0][`CSR_XLEN] : 1'b0;
        exp_data[1] = (pend[1] > 0) ? exp_q1[0][`CSR_XLEN-1:0] : '0;
        exp_exc[1]  = (pend[1] > 0) ? exp_q1[0][`CSR_XLEN] : 1'b0;
    endtask

    // Inputs only move on the rising edge, so this sees what the next edge takes
    always @(negedge clk) begin
        for (int m = 0; m < 2; m++) begin
            req_seen[m]  = nrst && req_valid[m] && req_ready[m];
            resp_seen[m] = nrst && resp_valid[m] && resp_ready[m];
            seen_op[m]   = req_op[m];
            seen_addr[m] = req_addr[m];
            seen_data[m] = req_data[m];
        end
    end

    always @(posedge clk) begin
        if (resp_seen[0] && exp_q0.size() > 0) begin
            exp_q0.delete(0);
        end
        if (resp_seen[1] && exp_q1.size() > 0) begin
            exp_q1.delete(0);
        end
        for (int m = 0; m < 2; m++) begin
            if (req_seen[m]) begin
                model_access(m, seen_op[m], seen_addr[m], seen_data[m]);
            end
        end
        refresh_front();
    end

    // Random back-pressure on both response channels
    always @(posedge clk) begin
        logic [`CSR_XLEN-1:0] stall_bits;
        if (stall_en) begin
            take_bits(2, stall_bits);
            resp_ready[0] <= stall_bits[0];
            resp_ready[1] <= stall_bits[1];
        end else begin
            resp_ready[0] <= 1'b1;
            resp_ready[1] <= 1'b1;
        end
    end

    a_reset_quiet: assert property (@(negedge clk)
        !nrst |-> !req_ready[0] && !req_ready[1] && !resp_valid[0] && !resp_valid[1])
        else report_mismatch("ready or response active during reset");
    a_m0_resp_match: assert property (@(negedge clk) disable iff (!nrst)
        resp_valid[0] && resp_ready[0] |->
            pend[0] > 0 && resp_data[0] == exp_data[0] && resp_exc[0] == exp_exc[0])
        else report_mismatch($sformatf("master 0 got %h/%0b, expected %h/%0b",
            resp_data[0], resp_exc[0], exp_data[0], exp_exc[0]));
    a_m1_resp_match: assert property (@(negedge clk) disable iff (!nrst)
        resp_valid[1] && resp_ready[1] |->
            pend[1] > 0 && resp_data[1] == exp_data[1] && resp_exc[1] == exp_exc[1])
        else report_mismatch($sformatf("master 1 got %h/%0b, expected %h/%0b",
            resp_data[1], resp_exc[1], exp_data[1], exp_exc[1]));
    a_m0_resp_hold: assert property (@(negedge clk) disable iff (!nrst)
        resp_valid[0] && !resp_ready[0] |=>
            resp_valid[0] && $stable(resp_data[0]) && $stable(resp_exc[0]))
        else report_mismatch("master 0 response changed while stalled");
    a_m1_resp_hold: assert property (@(negedge clk) disable iff (!nrst)
        resp_valid[1] && !resp_ready[1] |=>
            resp_valid[1] && $stable(resp_data[1]) && $stable(resp_exc[1]))
        else report_mismatch("master 1 response changed while stalled");
    a_m0_holds_bus: assert property (@(negedge clk) disable iff (!nrst)
        resp_valid[0] |-> !req_ready[1] && !resp_valid[1])
        else report_mismatch("master 1 served while master 0 holds the grant");
    a_m1_holds_bus: assert property (@(negedge clk) disable iff (!nrst)
        resp_valid[1] |-> !req_ready[0] && !resp_valid[0])
        else report_mismatch("master 0 served while master 1 holds the grant");
    a_m0_priority: assert property (@(negedge clk) disable iff (!nrst)
        req_valid[0] && req_valid[1] |-> !req_ready[1])
        else report_mismatch("master 1 accepted ahead of master 0");

    task automatic issue(input int m, input csr_op_e op,
                         input logic [`CSR_ADDR_W-1:0] addr, input logic [`CSR_XLEN-1:0] data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        req_valid[m] <= 1'b1;
        req_op[m]    <= op;
        req_addr[m]  <= addr;
        req_data[m]  <= data;
        @(negedge clk);
        while (!req_ready[m]) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_timeout($sformatf("Timeout: master %0d request was never accepted", m));
            end
            @(negedge clk);
        end
        @(posedge clk);
        req_valid[m] <= 1'b0;
    endtask

    initial begin
        int                   cycles;
        logic [`CSR_XLEN-1:0] bits;
        nrst       = 1'b0;
        stall_en   = 1'b0;
        lfsr_state = 32'h5d23_8803;
        for (int m = 0; m < 2; m++) begin
            req_valid[m] = 1'b0;
            req_op[m]    = CSR_OP_READ;
            req_addr[m]  = '0;
            req_data[m]  = '0;
        end
        model_reg = '{`CSR_MISA_VALUE, '0, '0, '0, '0};
        repeat (4) @(posedge clk);
        nrst <= 1'b1;

        // Reset values, then write, set and clear on every writable register
        foreach (CSR_ADDRS[i]) issue(0, CSR_OP_READ, CSR_ADDRS[i], '0);
        for (int i = 1; i < 5; i++) begin
            issue(0, CSR_OP_WRITE, CSR_ADDRS[i], 64'hdead_beef_0123_4567);
            issue(0, CSR_OP_SET, CSR_ADDRS[i], 64'h0000_00f0_0000_000b);
            issue(0, CSR_OP_CLEAR, CSR_ADDRS[i], 64'hff00_0000_0000_0001);
            issue(0, CSR_OP_READ, CSR_ADDRS[i], '0);
        end
        issue(0, CSR_OP_WRITE, CSR_ADDR_MTVEC, 64'h0000_0000_8000_0101);
        issue(0, CSR_OP_WRITE, CSR_ADDR_MTVEC, 64'h0000_0000_8000_0102);
        issue(0, CSR_OP_READ, CSR_ADDR_MTVEC, '0);

        // Faulting accesses leave the registers alone
        issue(0, CSR_OP_READ, 12'h7c0, '0);
        issue(0, CSR_OP_WRITE, 12'h000, '1);
        issue(0, CSR_OP_WRITE, CSR_ADDR_MISA, '0);
        issue(0, CSR_OP_SET, CSR_ADDR_MISA, '1);
        issue(0, CSR_OP_CLEAR, CSR_ADDR_MISA, '1);
        issue(0, CSR_OP_READ, CSR_ADDR_MISA, '0);
        issue(1, CSR_OP_READ, CSR_ADDR_MSCRATCH, '0);

        // Both masters on the same edge
        fork
            issue(0, CSR_OP_WRITE, CSR_ADDR_MSCRATCH, 64'h1111_2222_3333_4444);
            issue(1, CSR_OP_READ, CSR_ADDR_MSCRATCH, '0);
        join
        fork
            issue(0, CSR_OP_CLEAR, CSR_ADDR_MCAUSE, '1);
            issue(1, CSR_OP_SET, CSR_ADDR_MCAUSE, 64'h8000_0000_0000_000b);
        join

        // Random stream from both masters under back-pressure
        @(negedge clk);
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < STREAM_LEN; i++) begin
                take_bits(3, bits);
                if (bits[2:0] < 3'd5) begin
                    rnd_addr[m][i] = CSR_ADDRS[bits[2:0]];
                end else begin
                    take_bits(8, bits);
                    rnd_addr[m][i] = {4'hb, bits[7:0]};
                end
                take_bits(2, bits);
                rnd_op[m][i] = csr_op_e'(bits[1:0]);
                take_bits(`CSR_XLEN, rnd_data[m][i]);
            end
        end
        stall_en = 1'b1;
        fork
            for (int i = 0; i < STREAM_LEN; i++) begin
                issue(0, rnd_op[0][i], rnd_addr[0][i], rnd_data[0][i]);
            end
            for (int i = 0; i < STREAM_LEN; i++) begin
                issue(1, rnd_op[1][i], rnd_addr[1][i], rnd_data[1][i]);
            end
        join

        cycles = 0;
        @(negedge clk);
        while (pend[0] != 0 || pend[1] != 0) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_on_timeout("Timeout: responses still outstanding after the last request");
            end
            @(negedge clk);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_ic_m2_s1.sv
hdl/csr_regfile.sv
hdl/csr_subsystem.sv
test/tb_csr_subsystem.sv

// File: Makefile
# Verilator flow for the CSR subsystem
TOP := tb_csr_subsystem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall +incdir+hdl \
		hdl/csr_pkg.sv hdl/csr_ic_m2_s1.sv hdl/csr_regfile.sv hdl/csr_subsystem.sv \
		--top-module csr_subsystem

sim:
	verilator --binary --timing --assert -f filelist.f \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
